/* compile.f */
decode_pkg.sv
decode_ifs.sv
operand_extract.sv
op_classify.sv
decode_output_stage.sv
instruction_decoder.sv
tb_instruction_decoder.sv

/* Bender.yml */
package:
  name: instruction_decoder

sources:
  - decode_pkg.sv
  - decode_ifs.sv
  - operand_extract.sv
  - op_classify.sv
  - decode_output_stage.sv
  - instruction_decoder.sv
  - target: test
    files:
      - tb_instruction_decoder.sv

/* tb_instruction_decoder.sv */
// Runs the decoder at XLEN 64 only, so the XLEN 32 gating is not exercised here
`timescale 1ns/1ps

module tb_instruction_decoder;

    localparam int XLEN     = 64;
    localparam int MAX_ROWS = 40;
    localparam int TIMEOUT  = 200; // Cycles allowed per handshake wait

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    logic [31:0]           in_instr;
    logic [XLEN-1:0]       in_pc;
    logic                  out_valid;
    logic                  out_ready;
    logic [6:0]            out_opcode;
    decode_pkg::op_type_e  out_op_type;
    decode_pkg::reg_idx_t  out_rd;
    decode_pkg::reg_idx_t  out_rs1;
    decode_pkg::reg_idx_t  out_rs2;
    logic [XLEN-1:0]       out_imm;
    logic [XLEN-1:0]       out_shamt;
    decode_pkg::mem_size_e out_data_size;
    logic                  out_mem_read;
    logic                  out_mem_write;
    logic [XLEN-1:0]       out_pc;

    // Stimulus table with one entry per instruction
    string                 row_name [MAX_ROWS];
    logic [31:0]           row_instr [MAX_ROWS];
    logic [6:0]            row_opc [MAX_ROWS];
    logic [XLEN-1:0]       row_pc [MAX_ROWS];
    decode_pkg::op_type_e  row_op [MAX_ROWS];
    decode_pkg::reg_idx_t  row_rd [MAX_ROWS];
    decode_pkg::reg_idx_t  row_rs1 [MAX_ROWS];
    decode_pkg::reg_idx_t  row_rs2 [MAX_ROWS];
    logic [XLEN-1:0]       row_imm [MAX_ROWS];
    logic [XLEN-1:0]       row_shamt [MAX_ROWS];
    decode_pkg::mem_size_e row_size [MAX_ROWS];
    logic                  row_read [MAX_ROWS];
    logic                  row_write [MAX_ROWS];

    int          n_rows;
    int          err_count;
    int          timeout_count;
    logic        stalled; // Set once any handshake times out
    logic [31:0] lfsr;

    instruction_decoder #(.XLEN(XLEN)) instruction_decoder_i (.*);

    always #10 clk = ~clk;

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic check_op_type(input string name, input decode_pkg::op_type_e exp, act);
        if (act !== exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_opcode(input string name, input logic [6:0] exp, act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_reg(input string name, input decode_pkg::reg_idx_t exp, act);
        if (act !== exp) begin
            $display("error %s: expected x%0d, actual x%0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp, act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_size(input string name, input decode_pkg::mem_size_e exp, act);
        if (act !== exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        if (act !== exp) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] instr, input logic [6:0] opc,
                           input int op, input decode_pkg::reg_idx_t rd, rs1, rs2,
                           input logic [XLEN-1:0] imm, input int shamt, input int size,
                           input logic rd_mem, wr_mem);
        row_name[n_rows]  = name;
        row_instr[n_rows] = instr;
        row_opc[n_rows]   = opc;
        row_pc[n_rows]    = 64'h0000_0040_0000_1000 + XLEN'(n_rows * 4); // Unique per row
        row_op[n_rows]    = decode_pkg::op_type_e'(op);
        row_rd[n_rows]    = rd;
        row_rs1[n_rows]   = rs1;
        row_rs2[n_rows]   = rs2;
        row_imm[n_rows]   = imm;
        row_shamt[n_rows] = XLEN'(shamt);
        row_size[n_rows]  = decode_pkg::mem_size_e'(size);
        row_read[n_rows]  = rd_mem;
        row_write[n_rows] = wr_mem;
        n_rows++;
    endtask

    task automatic load_table();
        // name, word, opcode, op, rd, rs1, rs2, imm, shamt, size, mem_read, mem_write
        add_row("add", 32'h003100b3, 7'h33, 0, 1, 2, 3, 64'h0, 0, 0, 0, 0);
        add_row("sub", 32'h407302b3, 7'h33, 1, 5, 6, 7, 64'h0, 0, 0, 0, 0);
        add_row("mul", 32'h02c58533, 7'h33, 10, 10, 11, 12, 64'h0, 0, 0, 0, 0);
        add_row("mulhu", 32'h03df3fb3, 7'h33, 13, 31, 30, 29, 64'h0, 0, 0, 0, 0);
        add_row("sra", 32'h4044d433, 7'h33, 7, 8, 9, 4, 64'h0, 0, 0, 0, 0);
        add_row("remu", 32'h0307f733, 7'h33, 17, 14, 15, 16, 64'h0, 0, 0, 0, 0);
        add_row("addw", 32'h003100bb, 7'h3b, 33, 1, 2, 3, 64'h0, 0, 0, 0, 0);
        add_row("sraw", 32'h416ada3b, 7'h3b, 37, 20, 21, 22, 64'h0, 0, 0, 0, 0);
        add_row("divuw", 32'h025251bb, 7'h3b, 40, 3, 4, 5, 64'h0, 0, 0, 0, 0);
        add_row("addi", 32'hff010093, 7'h13, 18, 1, 2, 0, 64'hffff_ffff_ffff_fff0, 0, 0, 0, 0);
        add_row("sltiu", 32'h7ff3b313, 7'h13, 26, 6, 7, 0, 64'h7ff, 0, 0, 0, 0);
        add_row("srai", 32'h42155493, 7'h13, 24, 9, 10, 0, 64'h421, 33, 0, 0, 0); // 6-bit shamt
        add_row("srliw", 32'h01f6559b, 7'h1b, 31, 11, 12, 0, 64'h1f, 31, 0, 0, 0);
        add_row("bne", 32'hfe209ee3, 7'h63, 48, 0, 1, 2, 64'hffff_ffff_ffff_fffc, 0, 0, 0, 0);
        add_row("jal", 32'h001000ef, 7'h6f, 53, 1, 0, 0, 64'h800, 0, 0, 0, 0); // imm[11] only
        add_row("jalr", 32'hfff280e7, 7'h67, 54, 1, 5, 0, 64'hffff_ffff_ffff_ffff, 0, 0, 0, 0);
        add_row("lui", 32'h800001b7, 7'h37, 55, 3, 0, 0, 64'hffff_ffff_8000_0000, 0, 0, 0, 0);
        add_row("auipc", 32'h12345217, 7'h17, 56, 4, 0, 0, 64'h1234_5000, 0, 0, 0, 0);
        add_row("lb", 32'h00010083, 7'h03, 59, 1, 2, 0, 64'h0, 0, 1, 1, 0);
        add_row("lh", 32'h00221183, 7'h03, 60, 3, 4, 0, 64'h2, 0, 2, 1, 0);
        add_row("lw", 32'hffc32283, 7'h03, 61, 5, 6, 0, 64'hffff_ffff_ffff_fffc, 0, 4, 1, 0);
        add_row("lbu", 32'h00144383, 7'h03, 62, 7, 8, 0, 64'h1, 0, 1, 1, 0);
        add_row("lhu", 32'h00655483, 7'h03, 63, 9, 10, 0, 64'h6, 0, 2, 1, 0);
        add_row("lwu", 32'h00866583, 7'h03, 64, 11, 12, 0, 64'h8, 0, 4, 1, 0);
        add_row("ld", 32'h01073683, 7'h03, 65, 13, 14, 0, 64'h10, 0, 7, 1, 0);
        add_row("sb", 32'h00740223, 7'h23, 43, 0, 8, 7, 64'h4, 0, 1, 0, 1);
        add_row("sh", 32'h00951123, 7'h23, 44, 0, 10, 9, 64'h2, 0, 2, 0, 1);
        add_row("sw", 32'h04b62023, 7'h23, 45, 0, 12, 11, 64'h40, 0, 4, 0, 1);
        add_row("sd", 32'hfe513c23, 7'h23, 46, 0, 2, 5, 64'hffff_ffff_ffff_fff8, 0, 7, 0, 1);
        add_row("ecall", 32'h00000073, 7'h73, 57, 10, 0, 0, 64'h0, 0, 0, 0, 0);
        add_row("ebreak", 32'h00100073, 7'h73, 58, 0, 0, 0, 64'h1, 0, 0, 0, 0);
        add_row("zero word", 32'h00000000, 7'h00, 255, 0, 0, 0, 64'h0, 0, 0, 0, 0);
        // Register fields still come from the R format
        add_row("bad funct7", 32'h203100b3, 7'h33, 255, 1, 2, 3, 64'h0, 0, 0, 0, 0);
        add_row("bad opcode", 32'hffffffff, 7'h7f, 255, 0, 0, 0, 64'h0, 0, 0, 0, 0);
    endtask

    task automatic compare_row(input int i);
        string n;
        n = row_name[i];
        check_opcode({n, " opcode"}, row_opc[i], out_opcode);
        check_op_type({n, " op_type"}, row_op[i], out_op_type);
        check_reg({n, " rd"}, row_rd[i], out_rd);
        check_reg({n, " rs1"}, row_rs1[i], out_rs1);
        check_reg({n, " rs2"}, row_rs2[i], out_rs2);
        check_word({n, " imm"}, row_imm[i], out_imm);
        check_word({n, " shamt"}, row_shamt[i], out_shamt);
        check_size({n, " data_size"}, row_size[i], out_data_size);
        check_flag({n, " mem_read"}, row_read[i], out_mem_read);
        check_flag({n, " mem_write"}, row_write[i], out_mem_write);
        check_word({n, " pc"}, row_pc[i], out_pc);
    endtask

    // Producer drives one row at a time and holds in_valid until accepted
    task automatic drive_rows();
        int waited;
        for (int i = 0; i < n_rows && !stalled; i++) begin
            in_valid <= 1'b1;
            in_instr <= row_instr[i];
            in_pc    <= row_pc[i];
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!in_ready && waited < TIMEOUT && !stalled);
            if (!in_ready && !stalled) begin
                $display("timeout: in_ready stayed low for %0d cycles at %s",
                         TIMEOUT, row_name[i]);
                timeout_count++;
                stalled = 1'b1;
            end
        end
        in_valid <= 1'b0;
    endtask

    // Consumer with random out_ready checks rows in order
    task automatic collect_rows();
        int                   waited;
        logic                 accepted;
        logic                 held;
        logic [XLEN-1:0]      hold_pc;
        logic [XLEN-1:0]      hold_imm;
        decode_pkg::op_type_e hold_op;
        held = 1'b0;
        for (int i = 0; i < n_rows && !stalled; i++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (held) begin // Record was stalled on the previous edge
                    check_flag({row_name[i], " held out_valid"}, 1'b1, out_valid);
                    check_word({row_name[i], " held pc"}, hold_pc, out_pc);
                    check_word({row_name[i], " held imm"}, hold_imm, out_imm);
                    check_op_type({row_name[i], " held op_type"}, hold_op, out_op_type);
                end
                held     = out_valid && !out_ready;
                accepted = out_valid && out_ready;
                hold_pc  = out_pc;
                hold_imm = out_imm;
                hold_op  = out_op_type;
                out_ready <= lfsr[0];
                lfsr = lfsr_next(lfsr);
            end while (!accepted && waited < TIMEOUT && !stalled);
            if (accepted) begin
                compare_row(i);
            end else if (!stalled) begin
                $display("timeout: no output record for %s within %0d cycles",
                         row_name[i], TIMEOUT);
                timeout_count++;
                stalled = 1'b1;
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        n_rows        = 0;
        err_count     = 0;
        timeout_count = 0;
        stalled       = 1'b0;
        lfsr          = 32'hb5a2;
        reset     <= 1'b1;
        in_valid  <= 1'b0;
        in_instr  <= '0;
        in_pc     <= '0;
        out_ready <= 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_flag("after reset out_valid", 1'b0, out_valid); // Nothing driven yet
        check_flag("after reset in_ready", 1'b1, in_ready);
        fork
            drive_rows();
            collect_rows();
        join
        if (!stalled) begin
            @(posedge clk);
            check_flag("drained out_valid", 1'b0, out_valid); // No extra record
        end
        $display("errors: %0d value, %0d timeout", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* instruction_decoder.sv */
// RV64IM decoder top, one cycle latency; XLEN is 64 or 32, no compressed instructions
`timescale 1ns/1ps

module instruction_decoder #(
    parameter int XLEN = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_instr,
    input  logic [XLEN-1:0]       in_pc,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [6:0]            out_opcode,
    output decode_pkg::op_type_e  out_op_type,
    output decode_pkg::reg_idx_t  out_rd,
    output decode_pkg::reg_idx_t  out_rs1,
    output decode_pkg::reg_idx_t  out_rs2,
    output logic [XLEN-1:0]       out_imm,
    output logic [XLEN-1:0]       out_shamt,
    output decode_pkg::mem_size_e out_data_size,
    output logic                  out_mem_read,
    output logic                  out_mem_write,
    output logic [XLEN-1:0]       out_pc
);

    operand_if #(.XLEN(XLEN)) operand_bus ();
    op_class_if               class_bus ();

    // Both paths see the same word in parallel
    operand_extract #(.XLEN(XLEN)) operand_extract_i (
        .instr (in_instr),
        .ops   (operand_bus.src)
    );

    op_classify #(.XLEN(XLEN)) op_classify_i (
        .instr (in_instr),
        .cls   (class_bus.src)
    );

    decode_output_stage #(.XLEN(XLEN)) decode_output_stage_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_ready      (in_ready),
        .ops           (operand_bus.dst),
        .cls           (class_bus.dst),
        .out_valid     (out_valid),
        .out_opcode    (out_opcode),
        .out_op_type   (out_op_type),
        .out_rd        (out_rd),
        .out_rs1       (out_rs1),
        .out_rs2       (out_rs2),
        .out_imm       (out_imm),
        .out_shamt     (out_shamt),
        .out_data_size (out_data_size),
        .out_mem_read  (out_mem_read),
        .out_mem_write (out_mem_write),
        .out_pc        (out_pc),
        .out_ready     (out_ready)
    );

endmodule

/* decode_output_stage.sv */
// One-entry output register; accepts a new word in the same cycle the held one drains
`timescale 1ns/1ps

module decode_output_stage #(
    parameter int XLEN = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [XLEN-1:0]       in_pc,
    output logic                  in_ready,
    operand_if.dst                ops,
    op_class_if.dst               cls,
    output logic                  out_valid,
    output logic [6:0]            out_opcode,
    output decode_pkg::op_type_e  out_op_type,
    output decode_pkg::reg_idx_t  out_rd,
    output decode_pkg::reg_idx_t  out_rs1,
    output decode_pkg::reg_idx_t  out_rs2,
    output logic [XLEN-1:0]       out_imm,
    output logic [XLEN-1:0]       out_shamt,
    output decode_pkg::mem_size_e out_data_size,
    output logic                  out_mem_read,
    output logic                  out_mem_write,
    output logic [XLEN-1:0]       out_pc,
    input  logic                  out_ready
);

    logic load; // Transfer on the input side this edge

    assign in_ready = !out_valid || out_ready; // Empty, or draining now
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Record is only written on an accepted word, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            out_opcode    <= cls.opcode;
            out_op_type   <= cls.op_type;
            out_data_size <= cls.data_size;
            out_mem_read  <= cls.mem_read;
            out_mem_write <= cls.mem_write;
            out_rd        <= ops.rd;
            out_rs1       <= ops.rs1;
            out_rs2       <= ops.rs2;
            out_imm       <= ops.imm;
            out_shamt     <= ops.shamt;
            out_pc        <= in_pc;
        end
    end

endmodule

/* op_classify.sv */
// Operation number and memory attributes; at XLEN 32 the W/IW groups, LWU, LD and SD are unknown
`timescale 1ns/1ps

module op_classify #(
    parameter int XLEN = 64
) (
    input decode_pkg::instr_word_u instr,
    op_class_if.src                cls
);

    localparam bit RV64 = (XLEN == 64);

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA and friends
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;   // imm[11:6] of 64-bit immediate shifts
    logic       shamt_ok; // At XLEN 32 shamt[5] must be clear

    assign funct3   = instr.r.funct3;
    assign funct7   = instr.r.funct7;
    assign funct6   = instr.i.imm[11:6];
    assign shamt_ok = RV64 || !instr.i.imm[5];

    always_comb begin
        cls.opcode    = instr.r.opcode;
        cls.op_type   = decode_pkg::OP_UNKNOWN;
        cls.data_size = decode_pkg::SIZE_NONE;

        case (instr.r.opcode)
            decode_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   cls.op_type = decode_pkg::ADD;
                    {F7_ALT, 3'b000}:    cls.op_type = decode_pkg::SUB;
                    {F7_BASE, 3'b100}:   cls.op_type = decode_pkg::XOR;
                    {F7_BASE, 3'b110}:   cls.op_type = decode_pkg::OR;
                    {F7_BASE, 3'b111}:   cls.op_type = decode_pkg::AND_;
                    {F7_BASE, 3'b001}:   cls.op_type = decode_pkg::SLL;
                    {F7_BASE, 3'b101}:   cls.op_type = decode_pkg::SRL;
                    {F7_ALT, 3'b101}:    cls.op_type = decode_pkg::SRA;
                    {F7_BASE, 3'b010}:   cls.op_type = decode_pkg::SLT;
                    {F7_BASE, 3'b011}:   cls.op_type = decode_pkg::SLTU;
                    {F7_MULDIV, 3'b000}: cls.op_type = decode_pkg::MUL;
                    {F7_MULDIV, 3'b001}: cls.op_type = decode_pkg::MULH;
                    {F7_MULDIV, 3'b010}: cls.op_type = decode_pkg::MULHSU;
                    {F7_MULDIV, 3'b011}: cls.op_type = decode_pkg::MULHU;
                    {F7_MULDIV, 3'b100}: cls.op_type = decode_pkg::DIV;
                    {F7_MULDIV, 3'b101}: cls.op_type = decode_pkg::DIVU;
                    {F7_MULDIV, 3'b110}: cls.op_type = decode_pkg::REM;
                    {F7_MULDIV, 3'b111}: cls.op_type = decode_pkg::REMU;
                    default: ;
                endcase
            end
            decode_pkg::OPC_OP_32: begin
                if (RV64) begin
                    case ({funct7, funct3})
                        {F7_BASE, 3'b000}:   cls.op_type = decode_pkg::ADDW;
                        {F7_ALT, 3'b000}:    cls.op_type = decode_pkg::SUBW;
                        {F7_BASE, 3'b001}:   cls.op_type = decode_pkg::SLLW;
                        {F7_BASE, 3'b101}:   cls.op_type = decode_pkg::SRLW;
                        {F7_ALT, 3'b101}:    cls.op_type = decode_pkg::SRAW;
                        {F7_MULDIV, 3'b000}: cls.op_type = decode_pkg::MULW;
                        {F7_MULDIV, 3'b100}: cls.op_type = decode_pkg::DIVW;
                        {F7_MULDIV, 3'b101}: cls.op_type = decode_pkg::DIVUW;
                        {F7_MULDIV, 3'b110}: cls.op_type = decode_pkg::REMW;
                        {F7_MULDIV, 3'b111}: cls.op_type = decode_pkg::REMUW;
                        default: ;
                    endcase
                end
            end
            decode_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: cls.op_type = decode_pkg::ADDI;
                    3'b100: cls.op_type = decode_pkg::XORI;
                    3'b110: cls.op_type = decode_pkg::ORI;
                    3'b111: cls.op_type = decode_pkg::ANDI;
                    3'b010: cls.op_type = decode_pkg::SLTI;
                    3'b011: cls.op_type = decode_pkg::SLTIU;
                    3'b001: if (funct6 == 6'b000000 && shamt_ok) cls.op_type = decode_pkg::SLLI;
                    3'b101: begin
                        if (funct6 == 6'b000000 && shamt_ok) cls.op_type = decode_pkg::SRLI;
                        else if (funct6 == 6'b010000 && shamt_ok) cls.op_type = decode_pkg::SRAI;
                    end
                    default: ;
                endcase
            end
            decode_pkg::OPC_OP_IMM_32: begin
                if (RV64) begin
                    case (funct3)
                        3'b000: cls.op_type = decode_pkg::ADDIW;
                        3'b001: if (funct7 == F7_BASE) cls.op_type = decode_pkg::SLLIW;
                        3'b101: begin
                            if (funct7 == F7_BASE) cls.op_type = decode_pkg::SRLIW;
                            else if (funct7 == F7_ALT) cls.op_type = decode_pkg::SRAIW;
                        end
                        default: ;
                    endcase
                end
            end
            decode_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000: {cls.op_type, cls.data_size} = {decode_pkg::LB, decode_pkg::SIZE_BYTE};
                    3'b001: {cls.op_type, cls.data_size} = {decode_pkg::LH, decode_pkg::SIZE_HALF};
                    3'b010: {cls.op_type, cls.data_size} = {decode_pkg::LW, decode_pkg::SIZE_WORD};
                    3'b100: {cls.op_type, cls.data_size} = {decode_pkg::LBU, decode_pkg::SIZE_BYTE};
                    3'b101: {cls.op_type, cls.data_size} = {decode_pkg::LHU, decode_pkg::SIZE_HALF};
                    3'b110: if (RV64) begin
                        {cls.op_type, cls.data_size} = {decode_pkg::LWU, decode_pkg::SIZE_WORD};
                    end
                    3'b011: if (RV64) begin
                        {cls.op_type, cls.data_size} = {decode_pkg::LD, decode_pkg::SIZE_DOUBLE};
                    end
                    default: ;
                endcase
            end
            decode_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000: {cls.op_type, cls.data_size} = {decode_pkg::SB, decode_pkg::SIZE_BYTE};
                    3'b001: {cls.op_type, cls.data_size} = {decode_pkg::SH, decode_pkg::SIZE_HALF};
                    3'b010: {cls.op_type, cls.data_size} = {decode_pkg::SW, decode_pkg::SIZE_WORD};
                    3'b011: if (RV64) begin
                        {cls.op_type, cls.data_size} = {decode_pkg::SD, decode_pkg::SIZE_DOUBLE};
                    end
                    default: ;
                endcase
            end
            decode_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: cls.op_type = decode_pkg::BEQ;
                    3'b001: cls.op_type = decode_pkg::BNE;
                    3'b100: cls.op_type = decode_pkg::BLT;
                    3'b101: cls.op_type = decode_pkg::BGE;
                    3'b110: cls.op_type = decode_pkg::BLTU;
                    3'b111: cls.op_type = decode_pkg::BGEU;
                    default: ;
                endcase
            end
            decode_pkg::OPC_JAL:   cls.op_type = decode_pkg::JAL;
            decode_pkg::OPC_JALR:  if (funct3 == 3'b000) cls.op_type = decode_pkg::JALR;
            decode_pkg::OPC_LUI:   cls.op_type = decode_pkg::LUI;
            decode_pkg::OPC_AUIPC: cls.op_type = decode_pkg::AUIPC;
            decode_pkg::OPC_SYSTEM: begin
                if (funct3 == 3'b000 && instr.i.imm == 12'h000) cls.op_type = decode_pkg::ECALL;
                else if (funct3 == 3'b000 && instr.i.imm == 12'h001) begin
                    cls.op_type = decode_pkg::EBREAK;
                end
            end
            default: ; // Zero word lands here too
        endcase

        // Only a recognized load or store touches memory
        cls.mem_read  = (instr.r.opcode == decode_pkg::OPC_LOAD) &&
                        (cls.op_type != decode_pkg::OP_UNKNOWN);
        cls.mem_write = (instr.r.opcode == decode_pkg::OPC_STORE) &&
                        (cls.op_type != decode_pkg::OP_UNKNOWN);
    end

endmodule

/* operand_extract.sv */
// Operand fields by format; unused fields are zero, XLEN must be 32 or 64
`timescale 1ns/1ps

module operand_extract #(
    parameter int XLEN = 64
) (
    input decode_pkg::instr_word_u instr,
    operand_if.src                 ops
);

    localparam int SHAMT_W = (XLEN == 64) ? 6 : 5;

    logic is_shift; // funct3 001 or 101 in the immediate groups

    assign is_shift = (instr.i.funct3 == 3'b001) || (instr.i.funct3 == 3'b101);

    always_comb begin
        ops.rd    = '0;
        ops.rs1   = '0;
        ops.rs2   = '0;
        ops.imm   = '0;
        ops.shamt = '0;

        case (instr.r.opcode)
            decode_pkg::OPC_OP,
            decode_pkg::OPC_OP_32: begin
                ops.rd  = instr.r.rd;
                ops.rs1 = instr.r.rs1;
                ops.rs2 = instr.r.rs2;
            end
            decode_pkg::OPC_OP_IMM: begin
                ops.rd  = instr.i.rd;
                ops.rs1 = instr.i.rs1;
                ops.imm = XLEN'($signed(instr.i.imm));
                if (is_shift) begin
                    ops.shamt = XLEN'(instr.i.imm[SHAMT_W-1:0]);
                end
            end
            decode_pkg::OPC_OP_IMM_32: begin
                ops.rd  = instr.i.rd;
                ops.rs1 = instr.i.rs1;
                ops.imm = XLEN'($signed(instr.i.imm));
                if (is_shift) begin
                    ops.shamt = XLEN'(instr.i.imm[4:0]); // Word shifts are always 5 bits
                end
            end
            decode_pkg::OPC_LOAD,
            decode_pkg::OPC_JALR: begin
                ops.rd  = instr.i.rd;
                ops.rs1 = instr.i.rs1;
                ops.imm = XLEN'($signed(instr.i.imm));
            end
            decode_pkg::OPC_STORE: begin
                ops.rs1 = instr.s.rs1;
                ops.rs2 = instr.s.rs2;
                ops.imm = XLEN'($signed({instr.s.imm_hi, instr.s.imm_lo}));
            end
            decode_pkg::OPC_BRANCH: begin
                ops.rs1 = instr.b.rs1;
                ops.rs2 = instr.b.rs2;
                ops.imm = XLEN'($signed({instr.b.imm12, instr.b.imm11, instr.b.imm10_5,
                                         instr.b.imm4_1, 1'b0}));
            end
            decode_pkg::OPC_JAL: begin
                ops.rd  = instr.j.rd;
                ops.imm = XLEN'($signed({instr.j.imm20, instr.j.imm19_12, instr.j.imm11,
                                         instr.j.imm10_1, 1'b0}));
            end
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC: begin
                ops.rd  = instr.u.rd;
                ops.imm = XLEN'($signed({instr.u.imm, 12'b0})); // Upper 20 bits, already shifted
            end
            decode_pkg::OPC_SYSTEM: begin
                ops.imm = XLEN'($signed(instr.i.imm));
                // ECALL names a0 so the writeback sees the syscall result register
                if (instr.i.funct3 == 3'b000 && instr.i.imm == 12'h000) begin
                    ops.rd = decode_pkg::ECALL_RD;
                end
            end
            default: ; // Unknown opcode, all zero
        endcase
    end

endmodule

/* decode_ifs.sv */
// Combinational decode buses; no handshake, values follow the current instruction word
`timescale 1ns/1ps

interface operand_if #(
    parameter int XLEN = 64
);
    decode_pkg::reg_idx_t rd;
    decode_pkg::reg_idx_t rs1;
    decode_pkg::reg_idx_t rs2;
    logic [XLEN-1:0]      imm;   // Sign-extended
    logic [XLEN-1:0]      shamt; // Zero-extended

    modport src (
        output rd,
        output rs1,
        output rs2,
        output imm,
        output shamt
    );

    modport dst (
        input rd,
        input rs1,
        input rs2,
        input imm,
        input shamt
    );
endinterface

interface op_class_if;
    logic [6:0]            opcode; // Raw, also for unknown opcodes
    decode_pkg::op_type_e  op_type;
    decode_pkg::mem_size_e data_size;
    logic                  mem_read;
    logic                  mem_write;

    modport src (
        output opcode,
        output op_type,
        output data_size,
        output mem_read,
        output mem_write
    );

    modport dst (
        input opcode,
        input op_type,
        input data_size,
        input mem_read,
        input mem_write
    );
endinterface

/* decode_pkg.sv */
// Shared decode types; op_type_e numbering is fixed by the core, 255 marks any word not decoded
package decode_pkg;

    typedef logic [4:0] reg_idx_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_STORE     = 7'b0100011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_SYSTEM    = 7'b1110011,
        OPC_LOAD      = 7'b0000011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One word, six format views
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
        logic [31:0] raw;
    } instr_word_u;

    typedef enum logic [7:0] {
        ADD = 8'd0, SUB = 8'd1, XOR = 8'd2, OR = 8'd3, AND_ = 8'd4,
        SLL = 8'd5, SRL = 8'd6, SRA = 8'd7, SLT = 8'd8, SLTU = 8'd9,
        MUL = 8'd10, MULH = 8'd11, MULHSU = 8'd12, MULHU = 8'd13,
        DIV = 8'd14, DIVU = 8'd15, REM = 8'd16, REMU = 8'd17,
        ADDI = 8'd18, XORI = 8'd19, ORI = 8'd20, ANDI = 8'd21,
        SLLI = 8'd22, SRLI = 8'd23, SRAI = 8'd24, SLTI = 8'd25, SLTIU = 8'd26,
        ADDIW = 8'd29, SLLIW = 8'd30, SRLIW = 8'd31, SRAIW = 8'd32,
        ADDW = 8'd33, SUBW = 8'd34, SLLW = 8'd35, SRLW = 8'd36, SRAW = 8'd37,
        MULW = 8'd38, DIVW = 8'd39, DIVUW = 8'd40, REMW = 8'd41, REMUW = 8'd42,
        SB = 8'd43, SH = 8'd44, SW = 8'd45, SD = 8'd46,
        BEQ = 8'd47, BNE = 8'd48, BLT = 8'd49, BGE = 8'd50, BLTU = 8'd51, BGEU = 8'd52,
        JAL = 8'd53, JALR = 8'd54, LUI = 8'd55, AUIPC = 8'd56,
        ECALL = 8'd57, EBREAK = 8'd58,
        LB = 8'd59, LH = 8'd60, LW = 8'd61, LBU = 8'd62, LHU = 8'd63,
        LWU = 8'd64, LD = 8'd65,
        OP_UNKNOWN = 8'd255
    } op_type_e;

    // Size codes as the memory stage expects them, 7 means doubleword
    typedef enum logic [2:0] {
        SIZE_NONE   = 3'd0,
        SIZE_BYTE   = 3'd1,
        SIZE_HALF   = 3'd2,
        SIZE_WORD   = 3'd4,
        SIZE_DOUBLE = 3'd7
    } mem_size_e;

    localparam reg_idx_t ECALL_RD = 5'd10; // a0, reported as destination of ECALL

endpackage
